//--- design/board_io_top.sv
// Board I/O subsystem: LED register and 8N1 UART transmitter on a
// Wishbone classic slave port. No ERR or RTY; UART writes stall via ack.
// Only sel[3] is decoded, for the third LED source flag.
// clks_per_bit sets the baud rate from the bus clock.
module board_io_top #(
   parameter int clks_per_bit = 417
) (
   input  logic        CLK_I,
   input  logic        arst_n,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [31:0] adr,
   input  logic [3:0]  sel,
   input  logic [31:0] wdat,
   output logic        ack,
   output logic [31:0] rdat,
   input  logic        rx,
   output logic        tx,
   output logic [3:0]  led
);

   io_pkg::io_op_e      led_op;
   io_pkg::io_op_e      uart_op;
   io_pkg::uart_state_e state;
   logic [31:0]         led_rdat;
   logic                uart_busy;
   logic                uart_taken;
   logic                rx_sync;
   logic                bit_tick;
   logic                run;
   logic                load;
   logic                shift;

   wb_io_decode u_decode (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .led_rdat   (led_rdat),
      .uart_busy  (uart_busy),
      .rx_sync    (rx_sync),
      .uart_taken (uart_taken),
      .led_op     (led_op),
      .uart_op    (uart_op),
      .ack        (ack),
      .rdat       (rdat)
   );

   led_ctrl u_led (
      .CLK_I    (CLK_I),
      .arst_n   (arst_n),
      .led_op   (led_op),
      .sel3     (sel[3]),
      .wdat     (wdat),
      .rx_sync  (rx_sync),
      .led      (led),
      .led_rdat (led_rdat)
   );

   // Baud timer owns the bit period
   uart_baud_timer #(
      .clks_per_bit (clks_per_bit)
   ) u_baud (
      .CLK_I    (CLK_I),
      .arst_n   (arst_n),
      .run      (run),
      .bit_tick (bit_tick)
   );

   uart_tx_fsm u_tx_fsm (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .uart_op    (uart_op),
      .bit_tick   (bit_tick),
      .state      (state),
      .run        (run),
      .load       (load),
      .shift      (shift),
      .uart_taken (uart_taken),
      .uart_busy  (uart_busy)
   );

   // Low byte of the write data is the character
   uart_line u_line (
      .CLK_I   (CLK_I),
      .arst_n  (arst_n),
      .state   (state),
      .load    (load),
      .shift   (shift),
      .wdat    (wdat[7:0]),
      .rx      (rx),
      .tx      (tx),
      .rx_sync (rx_sync)
   );

endmodule

//--- design/io_pkg.sv
// Shared constants and types for the board I/O subsystem.
// Peripherals are selected by one-hot address bits; the UART wins when both are set.
// Only bit 31 of the LED word is byte-lane qualified (select bit 3).
package io_pkg;

   // Address bits that select a peripheral
   localparam int led_adr_bit  = 2;
   localparam int uart_adr_bit = 3;

   // UART status word layout on reads
   localparam int uart_busy_bit = 0;
   localparam int uart_rx_bit   = 8;

   // LED word bit that picks the third LED source
   // 0 = written data, 1 = inverted RX line
   localparam int led_src_bit = 31;

   // Operation handed from the decoder to one peripheral
   typedef enum logic [1:0] {
      op_none  = 2'd0,
      op_read  = 2'd1,
      op_write = 2'd2
   } io_op_e;

   // Transmitter frame phases
   typedef enum logic [1:0] {
      st_idle  = 2'd0,
      st_start = 2'd1,
      st_data  = 2'd2,
      st_stop  = 2'd3
   } uart_state_e;

endpackage

//--- design/led_ctrl.sv
// Four-bit LED register with readback.
// The third LED can follow the inverted RX line instead of written data.
// The source flag is only written when byte select 3 is set.
module led_ctrl (
   input  logic               CLK_I,
   input  logic               arst_n,
   input  io_pkg::io_op_e     led_op,
   input  logic               sel3,
   input  logic [31:0]        wdat,
   input  logic               rx_sync,
   output logic [3:0]         led,
   output logic [31:0]        led_rdat
);

   logic src_is_rx;
   logic wr;

   assign wr = (led_op == io_pkg::op_write);

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         led       <= '0;
         src_is_rx <= 1'b0;
      end else begin
         if (wr) begin
            led[0] <= wdat[0];
            led[1] <= wdat[1];
            led[3] <= wdat[3];
            // Upper byte lane carries the source flag
            if (sel3) begin
               src_is_rx <= wdat[io_pkg::led_src_bit];
            end
         end
         // RX follow overrides written data
         if (src_is_rx) begin
            led[2] <= ~rx_sync;
         end else if (wr) begin
            led[2] <= wdat[2];
         end
      end
   end

   // Readback: LED bits and source flag
   always_comb begin
      led_rdat = '0;
      led_rdat[3:0] = led;
      led_rdat[io_pkg::led_src_bit] = src_is_rx;
   end

endmodule

//--- design/uart_baud_timer.sv
// Bit period timer for the UART transmitter.
// Held at its reload value while run is low.
// First tick comes a full period after run rises, then every clks_per_bit cycles.
// clks_per_bit must be at least 1.
module uart_baud_timer #(
   parameter int clks_per_bit = 417
) (
   input  logic CLK_I,
   input  logic arst_n,
   input  logic run,
   output logic bit_tick
);

   logic [31:0] cnt;

   // Tick in the last cycle of each period
   assign bit_tick = run & (cnt == '0);

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= 32'(clks_per_bit - 1);
      end else if (!run || bit_tick) begin
         // Reload when idle or at period end
         cnt <= 32'(clks_per_bit - 1);
      end else begin
         cnt <= cnt - 32'd1;
      end
   end

endmodule

//--- design/uart_line.sv
// Serial line side of the UART.
// TX is a flop so the pin never glitches; it idles high.
// RX is only synchronized, there is no receiver framing.
module uart_line (
   input  logic                  CLK_I,
   input  logic                  arst_n,
   input  io_pkg::uart_state_e   state,
   input  logic                  load,
   input  logic                  shift,
   input  logic [7:0]            wdat,
   input  logic                  rx,
   output logic                  tx,
   output logic                  rx_sync
);

   logic [7:0] tx_sr;
   logic       rx_meta;

   // Data shifts out LSB first, ones fill from the top for the stop bit
   always_ff @(posedge CLK_I) begin
      if (load) begin
         tx_sr <= wdat;
      end else if (shift) begin
         tx_sr <= {1'b1, tx_sr[7:1]};
      end
   end

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         tx <= 1'b1;
      end else if (load) begin
         // Start bit
         tx <= 1'b0;
      end else if (shift) begin
         tx <= tx_sr[0];
      end else if (state == io_pkg::st_idle) begin
         tx <= 1'b1;
      end
   end

   // Two-stage synchronizer, idle line level after reset
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

endmodule

//--- design/uart_tx_fsm.sv
// 8N1 transmit sequencer.
// A byte is only accepted in idle; otherwise the write waits (no queue).
// shift pulses on the start tick and on every data tick, nine in all,
// so the line register steps through data bits and then the stop level.
module uart_tx_fsm (
   input  logic                  CLK_I,
   input  logic                  arst_n,
   input  io_pkg::io_op_e        uart_op,
   input  logic                  bit_tick,
   output io_pkg::uart_state_e   state,
   output logic                  run,
   output logic                  load,
   output logic                  shift,
   output logic                  uart_taken,
   output logic                  uart_busy
);

   logic [2:0] bit_cnt;
   logic       accept;

   // New byte only when no frame is going
   assign accept = (state == io_pkg::st_idle) && (uart_op == io_pkg::op_write);

   assign load       = accept;
   assign uart_taken = accept;

   // Timer runs for the whole frame
   assign run       = (state != io_pkg::st_idle);
   assign uart_busy = run;

   // Advance the line on start and data ticks
   assign shift = bit_tick &
                  ((state == io_pkg::st_start) || (state == io_pkg::st_data));

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         state   <= io_pkg::st_idle;
         bit_cnt <= '0;
      end else begin
         case (state)
            io_pkg::st_idle: begin
               if (accept) begin
                  state <= io_pkg::st_start;
               end
            end
            io_pkg::st_start: begin
               if (bit_tick) begin
                  state   <= io_pkg::st_data;
                  bit_cnt <= '0;
               end
            end
            io_pkg::st_data: begin
               if (bit_tick) begin
                  // Eighth data bit done
                  if (bit_cnt == 3'd7) begin
                     state <= io_pkg::st_stop;
                  end
                  bit_cnt <= bit_cnt + 3'd1;
               end
            end
            io_pkg::st_stop: begin
               if (bit_tick) begin
                  state <= io_pkg::st_idle;
               end
            end
            default: begin
               state <= io_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

//--- design/wb_io_decode.sv
// Wishbone classic slave front end for the LED register and the UART.
// One access at a time; the master must hold its signals until ack.
// UART writes stall (ack held low) until the transmitter takes the byte.
// Reads of unmapped addresses return zero; writes there are dropped.
module wb_io_decode (
   input  logic               CLK_I,
   input  logic               arst_n,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  logic [31:0]        adr,
   input  logic [31:0]        led_rdat,
   input  logic               uart_busy,
   input  logic               rx_sync,
   input  logic               uart_taken,
   output io_pkg::io_op_e     led_op,
   output io_pkg::io_op_e     uart_op,
   output logic               ack,
   output logic [31:0]        rdat
);

   logic           access;
   logic           uart_sel;
   logic           led_sel;
   logic           ack_nxt;
   io_pkg::io_op_e bus_op;
   logic [31:0]    uart_status;
   logic [31:0]    rdat_nxt;

   // Access still waiting for its ack
   assign access = cyc & stb & ~ack;

   // UART has priority when both select bits are set
   assign uart_sel = adr[io_pkg::uart_adr_bit];
   assign led_sel  = adr[io_pkg::led_adr_bit] & ~uart_sel;

   assign bus_op = we ? io_pkg::op_write : io_pkg::op_read;

   assign led_op  = (access && led_sel)  ? bus_op : io_pkg::op_none;
   assign uart_op = (access && uart_sel) ? bus_op : io_pkg::op_none;

   // UART write acks once the byte is taken, everything else right away
   assign ack_nxt = access & ((uart_sel & we) ? uart_taken : 1'b1);

   // Status word: busy flag and raw RX level
   always_comb begin
      uart_status = '0;
      uart_status[io_pkg::uart_busy_bit] = uart_busy;
      uart_status[io_pkg::uart_rx_bit]   = rx_sync;
   end

   // Read data mux, zero for unmapped
   always_comb begin
      if (uart_sel) begin
         rdat_nxt = uart_status;
      end else if (led_sel) begin
         rdat_nxt = led_rdat;
      end else begin
         rdat_nxt = '0;
      end
   end

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= ack_nxt;
      end
   end

   // Read data is captured with the ack edge
   always_ff @(posedge CLK_I) begin
      if (access && !we) begin
         rdat <= rdat_nxt;
      end
   end

endmodule

//--- src.f
design/io_pkg.sv
design/wb_io_decode.sv
design/led_ctrl.sv
design/uart_baud_timer.sv
design/uart_tx_fsm.sv
design/uart_line.sv
design/board_io_top.sv
test/tb_board_io.sv

//--- test/tb_board_io.sv
// Testbench for the board I/O subsystem through its Wishbone slave port.
// Runs with clks_per_bit = 8 so that a whole frame lasts 80 clock cycles.
// Bus accesses are single and blocking with an idle cycle in between.
module tb_board_io;

   localparam int clks_per_bit = 8;
   localparam int half_period  = 10;
   // Upper bound on the wait for any one ack or poll loop
   localparam int ack_limit    = 20 * clks_per_bit;
   // 12 frames of 10 bits plus margin
   localparam int watchdog_cycles = 12 * 10 * clks_per_bit + 2000;
   localparam time frame_time = 10 * clks_per_bit * 2 * half_period;
   localparam logic [31:0] led_adr  = 32'(1) << io_pkg::led_adr_bit;
   localparam logic [31:0] uart_adr = 32'(1) << io_pkg::uart_adr_bit;

   logic        CLK_I;
   logic        arst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [31:0] adr;
   logic [3:0]  sel;
   logic [31:0] wdat;
   logic        ack;
   logic [31:0] rdat;
   logic        rx;
   logic        tx;
   logic [3:0]  led;

   // Reference model of the LED register
   logic [3:0]  led_m;
   logic        src_m;
   logic [31:0] lfsr;
   int          errors;
   int          tests_run;
   int          tests_ok;
   int          rx_count;
   logic [7:0]  exp_q[$];
   logic [7:0]  rx_q[$];
   event        byte_seen;

   board_io_top #(
      .clks_per_bit (clks_per_bit)
   ) dut (
      .CLK_I  (CLK_I),
      .arst_n (arst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .sel    (sel),
      .wdat   (wdat),
      .ack    (ack),
      .rdat   (rdat),
      .rx     (rx),
      .tx     (tx),
      .led    (led)
   );

   always #half_period CLK_I = ~CLK_I;

   // Fibonacci LFSR with taps 32 22 2 1
   // One step per returned bit, newest bit in the LSB
   function automatic logic [31:0] take_bits(input int n);
      logic        fb;
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Expected read data from the model and the driven rx level
   function automatic logic [31:0] expect_rdat(input logic [31:0] a, input logic busy_exp);
      logic [31:0] r;
      r = '0;
      if (a[io_pkg::uart_adr_bit]) begin
         r[0] = busy_exp;
         r[8] = rx;
      end else if (a[io_pkg::led_adr_bit]) begin
         r[3:0] = led_m;
         r[31]  = src_m;
      end
      return r;
   endfunction

   // Bit 2 keeps ignoring written data while the flag was already set
   task automatic model_led_write(input logic [31:0] d, input logic [3:0] s);
      if (!src_m) begin
         led_m[2] = d[2];
      end
      led_m[0] = d[0];
      led_m[1] = d[1];
      led_m[3] = d[3];
      if (s[3]) begin
         src_m = d[31];
      end
      if (src_m) begin
         led_m[2] = ~rx;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge CLK_I);
      #2;
   endtask

   task automatic wb_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
      int n;
      n = 0;
      @(posedge CLK_I);
      #2;
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = 1'b1;
      adr  = a;
      sel  = s;
      wdat = d;
      do begin
         @(posedge CLK_I);
         #2;
         n++;
      end while (ack !== 1'b1 && n < ack_limit);
      assert (ack === 1'b1) else begin
         $display("no ack for write to %h after %0d cycles", a, n);
         errors++;
      end
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic wb_read(input logic [31:0] a, output logic [31:0] d);
      int n;
      n = 0;
      @(posedge CLK_I);
      #2;
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      sel = 4'hf;
      do begin
         @(posedge CLK_I);
         #2;
         n++;
      end while (ack !== 1'b1 && n < ack_limit);
      assert (ack === 1'b1) else begin
         $display("no ack for read of %h after %0d cycles", a, n);
         errors++;
      end
      d   = rdat;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   // Poll the status word until the transmitter is idle
   task automatic wait_idle();
      logic [31:0] r;
      int          n;
      n = 0;
      do begin
         wb_read(uart_adr, r);
         n++;
      end while (r[io_pkg::uart_busy_bit] && n < ack_limit);
      assert (!r[io_pkg::uart_busy_bit]) else begin
         $display("transmitter still busy after %0d status reads", n);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      tests_run++;
      if (errors == errs_at_start) begin
         tests_ok++;
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
      end
   endtask

   // Serial monitor sampling each bit near its middle on falling clock edges
   initial begin : serial_monitor
      logic [7:0] b;
      int         i;
      forever begin
         @(negedge CLK_I);
         if (tx === 1'b0) begin
            repeat (clks_per_bit / 2 - 1) @(negedge CLK_I);
            assert (tx === 1'b0) else begin
               $display("start bit on tx ended early at t=%0t", $time);
               errors++;
            end
            for (i = 0; i < 8; i++) begin
               repeat (clks_per_bit) @(negedge CLK_I);
               b[i] = tx;
            end
            repeat (clks_per_bit) @(negedge CLK_I);
            assert (tx === 1'b1) else begin
               $display("stop bit low for byte %h at t=%0t", b, $time);
               errors++;
            end
            rx_q.push_back(b);
            -> byte_seen;
         end
      end
   end

   // Received bytes against written bytes in order
   initial begin : byte_compare
      logic [7:0] got;
      forever begin
         @(byte_seen);
         while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            rx_count++;
            assert (exp_q.size() > 0) else begin
               $display("byte %h arrived on tx with no write pending", got);
               errors++;
            end
            if (exp_q.size() > 0) begin
               check_val("tx byte", got, exp_q.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      #(watchdog_cycles * 2 * half_period);
      $display("run stopped by watchdog after %0d cycles", watchdog_cycles);
      $display("tests failed");
      $finish;
   end

   initial begin : main
      logic [31:0] d;
      logic [31:0] r;
      logic [31:0] s;
      int          e0;
      int          i;
      time         t_first;
      time         t_second;
      CLK_I     = 1'b0;
      arst_n    = 1'b0;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      sel       = '0;
      wdat      = '0;
      rx        = 1'b1;
      led_m     = '0;
      src_m     = 1'b0;
      lfsr      = 32'h1b6f;
      errors    = 0;
      tests_run = 0;
      tests_ok  = 0;
      rx_count  = 0;
      repeat (8) @(posedge CLK_I);
      #2;
      arst_n = 1'b1;

      // Reset state
      e0 = errors;
      check_val("tx", tx, 1);
      check_val("led", led, 0);
      wb_read(uart_adr, r);
      check_val("rdat", r, expect_rdat(uart_adr, 1'b0));
      finish_test("reset state", e0);

      // LED writes with random data and byte selects while rx stays high
      e0 = errors;
      for (i = 0; i < 20; i++) begin
         d = take_bits(32);
         s = take_bits(4);
         wb_write(led_adr, d, s[3:0]);
         model_led_write(d, s[3:0]);
         wait_cycles(1);
         check_val("led", led, led_m);
         wb_read(led_adr, r);
         check_val("rdat", r, expect_rdat(led_adr, 1'b0));
      end
      finish_test("led write and readback", e0);

      // Third LED follows inverted rx once the flag is set
      e0 = errors;
      d = take_bits(32);
      d[io_pkg::led_src_bit] = 1'b1;
      wb_write(led_adr, d, 4'h8);
      model_led_write(d, 4'h8);
      for (i = 0; i < 4; i++) begin
         rx = i[0] ? 1'b1 : 1'b0;
         led_m[2] = ~rx;
         wait_cycles(3);
         check_val("led[2]", {31'b0, led[2]}, {31'b0, ~rx});
         d = take_bits(32);
         wb_write(led_adr, d, 4'h7);
         model_led_write(d, 4'h7);
         wait_cycles(1);
         check_val("led", led, led_m);
         wb_read(led_adr, r);
         check_val("rdat", r, expect_rdat(led_adr, 1'b0));
      end
      // Flag back to written data
      wb_write(led_adr, 32'h0, 4'h8);
      model_led_write(32'h0, 4'h8);
      wb_read(led_adr, r);
      check_val("rdat", r, expect_rdat(led_adr, 1'b0));
      finish_test("third led follows rx", e0);

      // Single bytes with idle time between frames
      e0 = errors;
      for (i = 0; i < 6; i++) begin
         d = take_bits(32);
         wb_write(uart_adr, d, 4'hf);
         exp_q.push_back(d[7:0]);
         wait_idle();
      end
      wait_cycles(2);
      check_val("bytes received", rx_count, 6);
      finish_test("uart transmit", e0);

      // Second write has to wait for the first frame to end
      e0 = errors;
      d = take_bits(32);
      wb_write(uart_adr, d, 4'hf);
      t_first = $time;
      exp_q.push_back(d[7:0]);
      wb_read(uart_adr, r);
      check_val("rdat", r, expect_rdat(uart_adr, 1'b1));
      d = take_bits(32);
      wb_write(uart_adr, d, 4'hf);
      t_second = $time;
      exp_q.push_back(d[7:0]);
      assert (t_second - t_first >= frame_time) else begin
         $display("second uart write acked %0t after the first, before the frame ended",
                  t_second - t_first);
         errors++;
      end
      wb_read(uart_adr, r);
      check_val("rdat", r, expect_rdat(uart_adr, 1'b1));
      wait_idle();
      wait_cycles(2);
      check_val("bytes received", rx_count, 8);
      finish_test("back-pressure", e0);

      // Neither select bit set
      e0 = errors;
      wb_read(32'h0000_0000, r);
      check_val("rdat", r, expect_rdat(32'h0000_0000, 1'b0));
      wb_read(32'h0000_0010, r);
      check_val("rdat", r, expect_rdat(32'h0000_0010, 1'b0));
      wb_write(32'h0000_0010, 32'hffff_ffff, 4'hf);
      for (i = 0; i < 2 * clks_per_bit; i++) begin
         wait_cycles(1);
         check_val("tx", tx, 1);
      end
      check_val("led", led, led_m);
      wb_read(uart_adr, r);
      check_val("rdat", r, expect_rdat(uart_adr, 1'b0));
      finish_test("unmapped address", e0);

      check_val("bytes pending", exp_q.size(), 0);
      $display("summary: %0d tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
      if (errors == 0 && tests_ok == tests_run) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
